//--- common/ym_timer_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// YM timer package
// Register numbers, timer timing constants and the types shared by
// the bus decoder, the timer registers, the counters and the status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ym_timer_pkg;

    // Timer registers in the lower bank
    localparam logic [7:0] REG_TIMER_A_HI = 8'h24;
    localparam logic [7:0] REG_TIMER_A_LO = 8'h25;
    localparam logic [7:0] REG_TIMER_B    = 8'h26;
    localparam logic [7:0] REG_TIMER_CTRL = 8'h27;

    localparam int BUSY_CYCLES = 8;     // Busy time after a data write
    localparam int TICK_DIV    = 4;     // clk cycles per timer A tick
    localparam int TICK_B_DIV  = 16;    // Timer A ticks per timer B tick

    localparam int BUSY_W   = $clog2(BUSY_CYCLES);
    localparam int TICK_W   = $clog2(TICK_DIV);
    localparam int TICK_B_W = $clog2(TICK_B_DIV);

    typedef logic [7:0] reg_num_t;
    typedef logic [9:0] timer_a_t;
    typedef logic [7:0] timer_b_t;

    // Layout of register 0x27
    typedef struct packed {
        logic [1:0] rsvd;
        logic       rst_flag_b;
        logic       rst_flag_a;
        logic       irq_en_b;
        logic       irq_en_a;
        logic       load_b;
        logic       load_a;
    } timer_ctrl_t;

    // Same data byte, seen as a value or as control bits
    typedef union packed {
        logic [7:0]  raw;
        timer_ctrl_t ctrl;
    } data_word_u;

    typedef struct packed {
        logic       wr;     // One-cycle write strobe
        reg_num_t   num;
        data_word_u data;
    } reg_wr_t;

    typedef struct packed {
        timer_a_t value_a;
        timer_b_t value_b;
        logic     load_a;
        logic     load_b;
        logic     irq_en_a;
        logic     irq_en_b;
    } timer_cfg_t;

    typedef struct packed {
        logic       busy;
        logic [4:0] zero;
        logic       flag_b;
        logic       flag_a;
    } status_t;

endpackage

//--- timers/ym_prescaler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer prescaler
// Free-running divider giving the timer A and timer B tick pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ym_prescaler (
    input  logic clk,
    input  logic rst,
    output logic tick_a,
    output logic tick_b
);
    import ym_timer_pkg::*;

    logic [TICK_W-1:0]   div_cnt;
    logic [TICK_B_W-1:0] b_cnt;     // Counts tick_a pulses

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            tick_a  <= 1'b0;
        end else if (div_cnt == TICK_W'(TICK_DIV - 1)) begin
            div_cnt <= '0;
            tick_a  <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick_a  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            b_cnt <= '0;
        end else if (tick_a) begin
            b_cnt <= b_cnt + 1'b1;  // Wraps after TICK_B_DIV ticks
        end
    end

    assign tick_b = tick_a & (b_cnt == TICK_B_W'(TICK_B_DIV - 1));

endmodule

//--- timers/ym_timer_cnt.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer counter
// Loadable up-counter that flags overflow at all ones and reloads
// its start value, shared by timer A and timer B
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ym_timer_cnt #(
    parameter int W = 10
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         tick,
    input  logic         load,
    input  logic [W-1:0] start_val,
    output logic         overflow
);

    logic [W-1:0] cnt;
    logic         load_d;
    logic         load_rise;

    assign load_rise = load & ~load_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            load_d <= 1'b0;
        end else begin
            load_d <= load;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (load_rise) begin
                cnt <= start_val;           // Start of a new run
            end else if (load && tick) begin
                if (&cnt) begin
                    cnt      <= start_val;
                    overflow <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/ym_bus_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus write decoder
// Latches the register number on address writes, issues one register
// write per lower-bank data write and runs the busy period
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ym_bus_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            din,
    input  logic [1:0]            addr,
    input  logic                  cs_n,
    input  logic                  wr_n,
    output ym_timer_pkg::reg_wr_t reg_wr,
    output logic                  busy
);
    import ym_timer_pkg::*;

    typedef enum logic {
        READY,
        BUSY
    } state_t;

    state_t              state;
    logic [BUSY_W-1:0]   busy_cnt;
    reg_num_t            reg_num;   // Latched register number
    logic                write;
    logic                addr_wr;
    logic                data_wr;

    assign write   = ~cs_n & ~wr_n;
    assign addr_wr = write & ~addr[0];
    // Upper bank is not present, so only addr 1 carries data
    assign data_wr = write & addr[0] & ~addr[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_num <= '0;
        end else if (addr_wr) begin
            reg_num <= din;
        end
    end

    // Write request goes out the cycle after the bus edge
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_wr.wr <= 1'b0;
        end else begin
            reg_wr.wr <= data_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            reg_wr.num      <= reg_num;
            reg_wr.data.raw <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= READY;
            busy_cnt <= '0;
        end else if (data_wr) begin
            // A new write restarts the busy time
            state    <= BUSY;
            busy_cnt <= BUSY_W'(BUSY_CYCLES - 1);
        end else begin
            case (state)
                READY: busy_cnt <= '0;
                BUSY: begin
                    if (busy_cnt == '0) begin
                        state <= READY;
                    end else begin
                        busy_cnt <= busy_cnt - 1'b1;
                    end
                end
                default: state <= READY;
            endcase
        end
    end

    assign busy = (state == BUSY);

endmodule

//--- hdl/ym_timer_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer register file
// Holds timer values and control bits of registers 0x24 to 0x27 and
// turns the flag reset bits into one-cycle clear pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ym_timer_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  ym_timer_pkg::reg_wr_t    reg_wr,
    output ym_timer_pkg::timer_cfg_t cfg,
    output logic                     clr_a,
    output logic                     clr_b
);
    import ym_timer_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg   <= '0;
            clr_a <= 1'b0;
            clr_b <= 1'b0;
        end else begin
            clr_a <= 1'b0;  // Pulses last one cycle
            clr_b <= 1'b0;
            if (reg_wr.wr) begin
                case (reg_wr.num)
                    REG_TIMER_A_HI: begin
                        cfg.value_a[9:2] <= reg_wr.data.raw;
                    end
                    REG_TIMER_A_LO: begin
                        cfg.value_a[1:0] <= reg_wr.data.raw[1:0];  // Two LSBs only
                    end
                    REG_TIMER_B: begin
                        cfg.value_b <= reg_wr.data.raw;
                    end
                    REG_TIMER_CTRL: begin
                        cfg.load_a   <= reg_wr.data.ctrl.load_a;
                        cfg.load_b   <= reg_wr.data.ctrl.load_b;
                        cfg.irq_en_a <= reg_wr.data.ctrl.irq_en_a;
                        cfg.irq_en_b <= reg_wr.data.ctrl.irq_en_b;
                        // Flag reset bits act once and are not kept
                        clr_a        <= reg_wr.data.ctrl.rst_flag_a;
                        clr_b        <= reg_wr.data.ctrl.rst_flag_b;
                    end
                    default: begin
                        // Other registers belong to the sound part
                    end
                endcase
            end
        end
    end

endmodule

//--- hdl/ym_status.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer flags and interrupt
// Sets the overflow flags when enabled, clears them on request and
// builds the status byte and the active-low interrupt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ym_status (
    input  logic                     clk,
    input  logic                     rst,
    input  ym_timer_pkg::timer_cfg_t cfg,
    input  logic                     ovf_a,
    input  logic                     ovf_b,
    input  logic                     clr_a,
    input  logic                     clr_b,
    input  logic                     busy,
    output ym_timer_pkg::status_t    status,
    output logic                     irq_n
);
    import ym_timer_pkg::*;

    logic flag_a;
    logic flag_b;
    logic flag_a_nx;
    logic flag_b_nx;

    // Clear has priority over a set in the same cycle
    assign flag_a_nx = clr_a ? 1'b0 : ((ovf_a & cfg.irq_en_a) | flag_a);
    assign flag_b_nx = clr_b ? 1'b0 : ((ovf_b & cfg.irq_en_b) | flag_b);

    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
            irq_n  <= 1'b1;
        end else begin
            flag_a <= flag_a_nx;
            flag_b <= flag_b_nx;
            irq_n  <= ~(flag_a_nx | flag_b_nx);  // Tracks the flags cycle for cycle
        end
    end

    assign status.busy   = busy;
    assign status.zero   = '0;
    assign status.flag_b = flag_b;
    assign status.flag_a = flag_a;

endmodule

//--- hdl/ym_timer_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FM chip timer and interrupt top level
// Connects the bus decoder, timer registers, prescaler, both timer
// counters and the status logic to the chip pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ym_timer_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            din,
    input  logic [1:0]            addr,
    input  logic                  cs_n,
    input  logic                  wr_n,
    output ym_timer_pkg::status_t dout,
    output logic                  irq_n
);
    import ym_timer_pkg::*;

    reg_wr_t    reg_wr;
    timer_cfg_t cfg;
    logic       busy;
    logic       clr_a, clr_b;
    logic       tick_a, tick_b;
    logic       ovf_a, ovf_b;

    ym_bus_fsm u_bus_fsm (
        .clk    (clk),
        .rst    (rst),
        .din    (din),
        .addr   (addr),
        .cs_n   (cs_n),
        .wr_n   (wr_n),
        .reg_wr (reg_wr),
        .busy   (busy)
    );

    ym_timer_regs u_timer_regs (
        .clk    (clk),
        .rst    (rst),
        .reg_wr (reg_wr),
        .cfg    (cfg),
        .clr_a  (clr_a),
        .clr_b  (clr_b)
    );

    ym_prescaler u_prescaler (
        .clk    (clk),
        .rst    (rst),
        .tick_a (tick_a),
        .tick_b (tick_b)
    );

    // Timer A, 10 bit
    ym_timer_cnt #(.W(10)) u_cnt_a (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick_a),
        .load      (cfg.load_a),
        .start_val (cfg.value_a),
        .overflow  (ovf_a)
    );

    ym_timer_cnt #(.W(8)) u_cnt_b (    // Timer B, 8 bit
        .clk       (clk),
        .rst       (rst),
        .tick      (tick_b),
        .load      (cfg.load_b),
        .start_val (cfg.value_b),
        .overflow  (ovf_b)
    );

    ym_status u_status (
        .clk    (clk),
        .rst    (rst),
        .cfg    (cfg),
        .ovf_a  (ovf_a),
        .ovf_b  (ovf_b),
        .clr_a  (clr_a),
        .clr_b  (clr_b),
        .busy   (busy),
        .status (dout),
        .irq_n  (irq_n)
    );

endmodule

//--- bench/tb_ym_timer_tasks.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timer testbench tasks
// Bus writes, LFSR, compare tasks and the directed test tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'h8020_0003;
    end
    return n;
endfunction

task automatic random_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < count; i++) begin
        bits       = {bits[30:0], lfsr_state[0]};  // One step per bit
        lfsr_state = lfsr_next(lfsr_state);
    end
endtask

task automatic step_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
endtask

// Holds cs_n and wr_n low for one clock edge
task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
    addr = a;
    din  = d;
    cs_n = 1'b0;
    wr_n = 1'b0;
    step_cycle();
    cs_n = 1'b1;
    wr_n = 1'b1;
endtask

task automatic write_addr(input reg_num_t num);
    bus_write(2'd0, num);
endtask

task automatic write_data(input logic [7:0] d);
    bus_write(2'd1, d);
endtask

task automatic write_reg(input reg_num_t num, input logic [7:0] d);
    write_addr(num);
    write_data(d);
endtask

function automatic status_t make_status(input logic busy, input logic flag_b,
                                        input logic flag_a);
    status_t s;
    s.busy   = busy;
    s.zero   = '0;
    s.flag_b = flag_b;
    s.flag_a = flag_a;
    return s;
endfunction

task automatic check_status(input string test, input status_t exp, input status_t act);
    if (act !== exp) begin
        abort_run($sformatf("[FAIL] %s: dout expected 0x%02h, actual 0x%02h",
                            test, exp, act));
    end
endtask

task automatic check_irq(input string test, input logic exp, input logic act);
    if (act !== exp) begin
        abort_run($sformatf("[FAIL] %s: irq_n expected %b, actual %b", test, exp, act));
    end
endtask

// No flag for the given span, busy high only for k < busy_left
task automatic check_quiet(input string test, input int cycles, input int busy_left);
    for (int k = 0; k <= cycles; k++) begin
        if (k > 0) begin
            step_cycle();
        end
        check_status(test, make_status(k < busy_left, 1'b0, 1'b0), dout);
        check_irq(test, 1'b1, irq_n);
    end
endtask

task automatic wait_flag(input string test, input logic want_b, input int min_cycles,
                         input int max_cycles, output int cycles);
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen) begin
        step_cycle();
        cycles++;
        seen = want_b ? dout.flag_b : dout.flag_a;
        if (!seen && cycles >= max_cycles) begin
            abort_run($sformatf("%s: flag not set within %0d cycles", test, max_cycles));
        end
    end
    if (cycles < min_cycles) begin
        abort_run($sformatf("%s: flag set after %0d cycles, before the %0d-cycle minimum",
                            test, cycles, min_cycles));
    end
endtask

task automatic test_reset_state();
    check_status("reset_state", make_status(1'b0, 1'b0, 1'b0), dout);
    check_irq("reset_state", 1'b1, irq_n);
endtask

task automatic test_busy_period();
    write_reg(REG_TIMER_A_HI, 8'h00);
    check_quiet("busy_period", BUSY_CYCLES, BUSY_CYCLES);
endtask

task automatic test_timer_a_irq();
    logic [31:0] r;
    int          cycles;
    random_bits(3, r);
    value_a = timer_a_t'(1016 + (r % 7));   // 1016 to 1022
    ticks_a = 1024 - int'(value_a);
    write_reg(REG_TIMER_A_HI, value_a[9:2]);
    write_reg(REG_TIMER_A_LO, {6'b0, value_a[1:0]});
    write_reg(REG_TIMER_CTRL, CTRL_EN_A | CTRL_LOAD_A);
    wait_flag("timer_a_irq", 1'b0, (ticks_a - 1) * TICK_DIV,
              (ticks_a + 1) * TICK_DIV + 2, cycles);
    check_status("timer_a_irq", make_status(cycles < BUSY_CYCLES, 1'b0, 1'b1), dout);
    check_irq("timer_a_irq", 1'b0, irq_n);
endtask

task automatic test_flag_a_clear();
    int cycles;
    write_reg(REG_TIMER_CTRL, CTRL_RST_A | CTRL_EN_A | CTRL_LOAD_A);
    step_cycle();
    step_cycle();   // Register update, then the flag clear
    check_status("flag_a_clear", make_status(1'b1, 1'b0, 1'b0), dout);
    check_irq("flag_a_clear", 1'b1, irq_n);
    wait_flag("flag_a_clear", 1'b0, 0, (ticks_a + 1) * TICK_DIV + 2, cycles);
    check_irq("flag_a_clear", 1'b0, irq_n);
    // Stop timer A and drop its flag
    write_reg(REG_TIMER_CTRL, CTRL_RST_A);
    step_cycle();
    step_cycle();
    check_quiet("timer_a_stop", (ticks_a + 1) * TICK_DIV + 2, BUSY_CYCLES - 2);
endtask

task automatic test_timer_b_enable();
    logic [31:0] r;
    timer_b_t    value_b;
    int          ticks_b;
    int          period;
    int          cycles;
    random_bits(2, r);
    value_b = timer_b_t'(252 + (r % 3));    // 252 to 254
    ticks_b = 256 - int'(value_b);
    period  = (ticks_b + 1) * TICK_DIV * TICK_B_DIV;
    write_reg(REG_TIMER_B, value_b);
    write_reg(REG_TIMER_CTRL, CTRL_LOAD_B);
    check_quiet("timer_b_masked", 2 * period, BUSY_CYCLES);
    write_reg(REG_TIMER_CTRL, CTRL_EN_B | CTRL_LOAD_B);
    wait_flag("timer_b_irq", 1'b1, 0, period + 2, cycles);
    check_status("timer_b_irq", make_status(cycles < BUSY_CYCLES, 1'b1, 1'b0), dout);
    check_irq("timer_b_irq", 1'b0, irq_n);
    write_reg(REG_TIMER_CTRL, CTRL_RST_B);
    step_cycle();
    step_cycle();
    check_quiet("timer_b_stop", BUSY_CYCLES, BUSY_CYCLES - 2);
endtask

// Upper bank data writes must not reach the timer registers
task automatic test_upper_bank_ignored();
    bus_write(2'd2, REG_TIMER_CTRL);
    bus_write(2'd3, CTRL_EN_A | CTRL_EN_B | CTRL_LOAD_A | CTRL_LOAD_B);
    check_quiet("upper_bank", (ticks_a + 1) * TICK_DIV + 2, 0);
endtask

//--- bench/tb_ym_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the FM chip timer and interrupt block
// Clock, reset, DUT instance, cycle timeout and the directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_ym_timer;
    import ym_timer_pkg::*;

    localparam int HALF_PERIOD  = 20;   // 40 ns clock
    localparam int DRIVE_DELAY  = 2;    // Inputs change after the edge
    localparam int RESET_CYCLES = 3;
    // Longest test is timer B, 2 masked periods plus one enabled period
    // of at most 5 x 64 cycles each, so 6000 leaves a wide margin
    localparam int TIMEOUT_CYCLES = 6000;

    // Control byte bits of register 0x27
    localparam logic [7:0] CTRL_LOAD_A = 8'h01;
    localparam logic [7:0] CTRL_LOAD_B = 8'h02;
    localparam logic [7:0] CTRL_EN_A   = 8'h04;
    localparam logic [7:0] CTRL_EN_B   = 8'h08;
    localparam logic [7:0] CTRL_RST_A  = 8'h10;
    localparam logic [7:0] CTRL_RST_B  = 8'h20;

    logic        clk;
    logic        rst;
    logic [7:0]  din;
    logic [1:0]  addr;
    logic        cs_n;
    logic        wr_n;
    status_t     dout;
    logic        irq_n;

    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    timer_a_t    value_a;       // Timer A start value, kept for later tests
    int          ticks_a;       // Ticks per timer A period

    ym_timer_top i_ym_timer_top (
        .clk   (clk),
        .rst   (rst),
        .din   (din),
        .addr  (addr),
        .cs_n  (cs_n),
        .wr_n  (wr_n),
        .dout  (dout),
        .irq_n (irq_n)
    );

    // Stops the run at the first error
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped after an error");
    endtask

    `include "tb_ym_timer_tasks.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: tests still running after %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    initial begin
        lfsr_state = 32'h76f4_6c69;
        value_a    = '0;
        ticks_a    = 0;
        rst        = 1'b1;
        din        = 8'h00;
        addr       = 2'd0;
        cs_n       = 1'b1;
        wr_n       = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        test_reset_state();
        test_busy_period();
        test_timer_a_irq();
        test_flag_a_clear();
        test_timer_b_enable();
        test_upper_bank_ignored();

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- ym_timer_top.f
+incdir+bench
common/ym_timer_pkg.sv
timers/ym_prescaler.sv
timers/ym_timer_cnt.sv
hdl/ym_bus_fsm.sv
hdl/ym_timer_regs.sv
hdl/ym_status.sv
hdl/ym_timer_top.sv
bench/tb_ym_timer.sv

//--- run_sim.sh
#!/bin/sh
# Builds the timer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

TOP=tb_ym_timer
LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps \
    --top-module "$TOP" -f ym_timer_top.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    echo "Simulation log shows a pass"
    exit 0
else
    echo "Pass line missing from $LOG"
    exit 1
fi
